/* run_sim.sh */
#!/bin/sh
# build and run the coherence bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_coh_bus -o tb_coh_bus

./obj_dir/tb_coh_bus > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "no pass message found in sim.log"
	exit 1
fi
echo "simulation passed"

/* sim/tb_coh_bus.sv */
`default_nettype none

module tb_coh_bus;

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 8;
	localparam int DRV_DLY = 10;
	localparam int NUM_RAND = 40;
	localparam int NUM_ALT = 8;
	localparam int STALL_CYCLES = 30;
	localparam int ADDR_W = bus_cfg_pkg::TAG_W + bus_cfg_pkg::IDX_W;
	localparam int MEM_WORDS = 2 ** ADDR_W;

	// watchdog bound from the transaction count
	localparam int NUM_TXN = bus_cfg_pkg::RSP_Q_NUM + 3 + 2 * NUM_RAND + 2 * NUM_ALT;
	localparam int TXN_CYCLES = 60;
	localparam int WATCHDOG_TIME = (RST_CYCLES + STALL_CYCLES + NUM_TXN * TXN_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		bus_cfg_pkg::core_id_t id;
		bus_cfg_pkg::tag_t tag;
		bus_cfg_pkg::idx_t idx;
		bus_cfg_pkg::word_t data;
	} exp_rsp_t;

	logic clk;
	logic rst;
	logic [1:0] req;
	bus_cfg_pkg::tag_t tag [2];
	bus_cfg_pkg::idx_t idx [2];
	bus_msg_pkg::message_t msg [2];
	bus_cfg_pkg::word_t data [2];
	wire [1:0] ack;

	wire rsp_vld;
	wire bus_cfg_pkg::core_id_t rsp_id;
	wire bus_cfg_pkg::tag_t rsp_tag;
	wire bus_cfg_pkg::idx_t rsp_idx;
	wire bus_cfg_pkg::word_t rsp_data;
	logic rsp_ack;

	// reference model
	bus_cfg_pkg::word_t model_mem [MEM_WORDS];
	int pend_cnt [MEM_WORDS];
	exp_rsp_t exp_q [$];
	exp_rsp_t exp_front;
	int exp_cnt;
	logic [1:0] blk_pend;

	logic [31:0] rng;
	logic rsp_on;
	logic alt_mode;
	logic [1:0] last_id;
	logic put_done;
	logic get_done;
	int err_cnt;
	int txn_cnt;
	int rsp_cnt;

	coh_bus_top coh_bus_top_i (
		.clk          (clk),
		.rst          (rst),
		.core0_req_i  (req[0]),
		.core0_tag_i  (tag[0]),
		.core0_idx_i  (idx[0]),
		.core0_msg_i  (msg[0]),
		.core0_data_i (data[0]),
		.core0_ack_o  (ack[0]),
		.core1_req_i  (req[1]),
		.core1_tag_i  (tag[1]),
		.core1_idx_i  (idx[1]),
		.core1_msg_i  (msg[1]),
		.core1_data_i (data[1]),
		.core1_ack_o  (ack[1]),
		.rsp_vld_o    (rsp_vld),
		.rsp_id_o     (rsp_id),
		.rsp_tag_o    (rsp_tag),
		.rsp_idx_o    (rsp_idx),
		.rsp_data_o   (rsp_data),
		.rsp_ack_i    (rsp_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------
	// helpers
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic bus_cfg_pkg::word_t rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic step();
		@(posedge clk);
		#DRV_DLY;
	endtask

	task automatic refresh_front();
		exp_cnt = exp_q.size();
		if (exp_cnt != 0) begin
			exp_front = exp_q[0];
		end
	endtask

	task automatic set_idle(input bus_cfg_pkg::core_id_t core);
		req[core] = 1'b0;
		msg[core] = bus_msg_pkg::NONE;
		tag[core] = '0;
		idx[core] = '0;
		data[core] = '0;
	endtask

	// model update at the core ack
	task automatic record_ack(input bus_cfg_pkg::core_id_t core);
		exp_rsp_t e;
		logic [ADDR_W-1:0] a;
		a = {tag[core], idx[core]};
		txn_cnt++;
		last_id = {1'b0, core};
		if (msg[core] == bus_msg_pkg::PUT_M) begin
			model_mem[a] = data[core];
		end else begin
			e.id = core;
			e.tag = tag[core];
			e.idx = idx[core];
			e.data = model_mem[a];
			exp_q.push_back(e);
			pend_cnt[a]++;
			refresh_front();
		end
	endtask

	task automatic pop_expected();
		exp_rsp_t e;
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			pend_cnt[{e.tag, e.idx}]--;
			rsp_cnt++;
			refresh_front();
		end
	endtask

	// one full four-phase request from a core
	task automatic drive_req(input bus_cfg_pkg::core_id_t core, input bus_msg_pkg::message_t m,
			input bus_cfg_pkg::tag_t t, input bus_cfg_pkg::idx_t x, input bus_cfg_pkg::word_t d);
		logic [31:0] hold;
		msg[core] = m;
		tag[core] = t;
		idx[core] = x;
		data[core] = d;
		req[core] = 1'b1;
		while (!ack[core]) step();
		record_ack(core);
		// req stays up a few cycles past the ack
		hold = rand_word();
		repeat (hold[1:0]) step();
		req[core] = 1'b0;
		while (ack[core]) step();
		set_idle(core);
	endtask

	task automatic serve_responses();
		logic [31:0] r;
		forever begin
			step();
			if (rsp_on && rsp_vld) begin
				r = rand_word();
				repeat (r[1:0]) step();
				rsp_ack = 1'b1;
				while (rsp_vld) step();
				pop_expected();
				repeat (r[3:2]) step();
				rsp_ack = 1'b0;
			end
		end
	endtask

	// few tags so that blocks collide often
	task automatic run_random(input bus_cfg_pkg::core_id_t core);
		logic [31:0] r;
		for (int i = 0; i < NUM_RAND; i++) begin
			r = rand_word();
			drive_req(core, r[8] ? bus_msg_pkg::PUT_M : bus_msg_pkg::GET_S,
				bus_cfg_pkg::tag_t'(r[0]), r[2:1], rand_word());
			repeat (r[5:4]) step();
		end
	endtask

	task automatic run_alternating(input bus_cfg_pkg::core_id_t core);
		for (int i = 0; i < NUM_ALT; i++) begin
			drive_req(core, bus_msg_pkg::PUT_M, bus_cfg_pkg::tag_t'(4 + core),
				bus_cfg_pkg::idx_t'(i), rand_word());
		end
	endtask

	task automatic wait_drain();
		while (exp_cnt != 0) step();
		repeat (4) step();
	endtask

	// --------------------
	// checks
	reset_chk: assert property (@(posedge clk) $fell(rst) |-> ack == 2'b00 && !rsp_vld)
		else begin
			err_cnt++;
			$display("Mismatch ack/rsp_vld_o after reset: got %h/%h expected 0/0",
				$sampled(ack), $sampled(rsp_vld));
		end

	for (genvar c = 0; c < 2; c++) begin : core_chk
		assign blk_pend[c] = (pend_cnt[{tag[c], idx[c]}] != 0);

		ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack[c]) |-> $past(req[c]))
			else begin
				err_cnt++;
				$display("core%0d ack rose without a request", c);
			end
		ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack[c]) |-> !$past(req[c]))
			else begin
				err_cnt++;
				$display("core%0d ack fell while the request was still high", c);
			end
		hazard: assert property (@(posedge clk) disable iff (rst)
			$rose(ack[c]) |-> !$past(blk_pend[c]))
			else begin
				err_cnt++;
				$display("core%0d acked a request to a block with an undelivered GET_S", c);
			end
		full: assert property (@(posedge clk) disable iff (rst)
			$rose(ack[c]) && $past(msg[c]) == bus_msg_pkg::GET_S |->
			$past(exp_cnt) < bus_cfg_pkg::RSP_Q_NUM)
			else begin
				err_cnt++;
				$display("core%0d acked a GET_S while the response queue was full", c);
			end
		alternate: assert property (@(posedge clk) disable iff (rst)
			alt_mode && $rose(ack[c]) |-> $past(last_id) != 2'(c))
			else begin
				err_cnt++;
				$display("core%0d acked twice in a row while both cores were requesting", c);
			end
	end

	rsp_any: assert property (@(posedge clk) disable iff (rst) rsp_vld |-> exp_cnt != 0)
		else begin
			err_cnt++;
			$display("response shown while no GET_S was outstanding");
		end
	rsp_id_chk: assert property (@(posedge clk) disable iff (rst)
		rsp_vld && exp_cnt != 0 |-> rsp_id == exp_front.id)
		else begin
			err_cnt++;
			$display("Mismatch rsp_id_o: got %h expected %h", $sampled(rsp_id), exp_front.id);
		end
	rsp_tag_chk: assert property (@(posedge clk) disable iff (rst)
		rsp_vld && exp_cnt != 0 |-> rsp_tag == exp_front.tag)
		else begin
			err_cnt++;
			$display("Mismatch rsp_tag_o: got %h expected %h", $sampled(rsp_tag), exp_front.tag);
		end
	rsp_idx_chk: assert property (@(posedge clk) disable iff (rst)
		rsp_vld && exp_cnt != 0 |-> rsp_idx == exp_front.idx)
		else begin
			err_cnt++;
			$display("Mismatch rsp_idx_o: got %h expected %h", $sampled(rsp_idx), exp_front.idx);
		end
	rsp_data_chk: assert property (@(posedge clk) disable iff (rst)
		rsp_vld && exp_cnt != 0 |-> rsp_data == exp_front.data)
		else begin
			err_cnt++;
			$display("Mismatch rsp_data_o: got %h expected %h", $sampled(rsp_data),
				exp_front.data);
		end
	rsp_rise: assert property (@(posedge clk) disable iff (rst) $rose(rsp_vld) |-> !$past(rsp_ack))
		else begin
			err_cnt++;
			$display("rsp_vld_o rose while rsp_ack_i was still high");
		end
	rsp_fall: assert property (@(posedge clk) disable iff (rst) $fell(rsp_vld) |-> $past(rsp_ack))
		else begin
			err_cnt++;
			$display("rsp_vld_o dropped before rsp_ack_i");
		end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout after %0d time units, the run did not complete", WATCHDOG_TIME);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// --------------------
	// test sequence
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		set_idle(1'b0);
		set_idle(1'b1);
		rsp_ack = 1'b0;
		rsp_on = 1'b0;
		alt_mode = 1'b0;
		last_id = 2'd2;
		put_done = 1'b0;
		get_done = 1'b0;
		err_cnt = 0;
		txn_cnt = 0;
		rsp_cnt = 0;
		rng = 32'd27481;
		model_mem = '{default: '0};
		pend_cnt = '{default: 0};
		refresh_front();
		repeat (RST_CYCLES) @(posedge clk);
		#DRV_DLY;
		rst = 1'b0;

		fork
			serve_responses();
		join_none

		// fill the queue with responses held back
		for (int i = 0; i < bus_cfg_pkg::RSP_Q_NUM; i++) begin
			drive_req(1'b0, bus_msg_pkg::GET_S, bus_cfg_pkg::tag_t'(8 + i), 2'd1, rand_word());
		end
		fork
			begin
				drive_req(1'b0, bus_msg_pkg::GET_S, 4'd14, 2'd3, rand_word());
				get_done = 1'b1;
			end
			begin
				drive_req(1'b1, bus_msg_pkg::PUT_M, 4'd13, 2'd2, rand_word());
				put_done = 1'b1;
				// same block as the oldest pending GET_S
				drive_req(1'b1, bus_msg_pkg::PUT_M, 4'd8, 2'd1, rand_word());
			end
			begin
				repeat (STALL_CYCLES) step();
				put_acked: assert (put_done)
					else begin
						err_cnt++;
						$display("PUT_M was not acked while the response queue was full");
					end
				get_held: assert (!get_done)
					else begin
						err_cnt++;
						$display("GET_S to a new block was acked while the response queue was full");
					end
				rsp_on = 1'b1;
			end
		join
		wait_drain();

		fork
			run_random(1'b0);
			run_random(1'b1);
		join
		wait_drain();

		// both cores busy, grants should alternate
		last_id = 2'd2;
		alt_mode = 1'b1;
		fork
			run_alternating(1'b0);
			run_alternating(1'b1);
		join
		alt_mode = 1'b0;
		wait_drain();

		$display("transactions %0d, responses %0d, errors %0d", txn_cnt, rsp_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
verilog/bus_cfg_pkg.sv
verilog/bus_msg_pkg.sv
verilog/bus_req_if.sv
verilog/pend_if.sv
verilog/req_arbiter.sv
verilog/rsp_queue.sv
verilog/mem_ctrl.sv
verilog/coh_bus_top.sv
sim/tb_coh_bus.sv

/* verilog/bus_cfg_pkg.sv */
`default_nettype none

package bus_cfg_pkg;

	// --------------------
	// address and data widths
	localparam int TAG_W = 4;
	localparam int IDX_W = 2;
	localparam int WORD_W = 32;

	// --------------------
	// response queue sizing
	localparam int RSP_Q_NUM = 4;
	localparam int RSP_Q_PTR_W = 2;

	// cycles from memory accept to queue fill
	localparam int MEM_LAT = 4;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [RSP_Q_PTR_W-1:0] qptr_t;

	// 0 is core 0, 1 is core 1
	typedef logic core_id_t;

endpackage

`default_nettype wire

/* verilog/bus_msg_pkg.sv */
`default_nettype none

package bus_msg_pkg;

	// bus messages
	typedef enum logic [1:0] {
		NONE = 2'd0,
		GET_S = 2'd1,
		PUT_M = 2'd2
	} message_t;

	// arbiter request FSM
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ISSUE = 2'd1,
		CORE_ACK = 2'd2,
		DRAIN = 2'd3
	} arb_state_t;

	// response delivery FSM
	typedef enum logic {
		SHOW = 1'b0,
		WAIT_LOW = 1'b1
	} rsp_state_t;

endpackage

`default_nettype wire

/* verilog/bus_req_if.sv */
`default_nettype none

// granted request, arbiter to memory controller
// the queue watches it and supplies the tail pointer
interface bus_req_if;

	logic req;
	logic ack;
	bus_cfg_pkg::core_id_t id;
	bus_cfg_pkg::tag_t tag;
	bus_cfg_pkg::idx_t idx;
	bus_msg_pkg::message_t msg;
	bus_cfg_pkg::word_t data;

	// queue entry a GET_S will take
	bus_cfg_pkg::qptr_t ptr;

	modport master (output req, id, tag, idx, msg, data, input ack);

	modport slave (input req, tag, idx, msg, data, ptr, output ack);

	modport monitor (input id, tag, idx, output ptr);

endinterface

`default_nettype wire

/* verilog/coh_bus_top.sv */
`default_nettype none

module coh_bus_top (
	input  wire                        clk,
	input  wire                        rst,

	input  wire                        core0_req_i,
	input  wire bus_cfg_pkg::tag_t     core0_tag_i,
	input  wire bus_cfg_pkg::idx_t     core0_idx_i,
	input  wire bus_msg_pkg::message_t core0_msg_i,
	input  wire bus_cfg_pkg::word_t    core0_data_i,
	output logic                       core0_ack_o,

	input  wire                        core1_req_i,
	input  wire bus_cfg_pkg::tag_t     core1_tag_i,
	input  wire bus_cfg_pkg::idx_t     core1_idx_i,
	input  wire bus_msg_pkg::message_t core1_msg_i,
	input  wire bus_cfg_pkg::word_t    core1_data_i,
	output logic                       core1_ack_o,

	output logic                       rsp_vld_o,
	output bus_cfg_pkg::core_id_t      rsp_id_o,
	output bus_cfg_pkg::tag_t          rsp_tag_o,
	output bus_cfg_pkg::idx_t          rsp_idx_o,
	output bus_cfg_pkg::word_t         rsp_data_o,
	input  wire                        rsp_ack_i
);

	bus_req_if bus_req ();
	pend_if pend ();

	// memory fill into the queue
	logic fill_vld;
	bus_cfg_pkg::qptr_t fill_ptr;
	bus_cfg_pkg::word_t fill_data;

	req_arbiter req_arbiter_i (
		.clk          (clk),
		.rst          (rst),
		.core0_req_i  (core0_req_i),
		.core0_tag_i  (core0_tag_i),
		.core0_idx_i  (core0_idx_i),
		.core0_msg_i  (core0_msg_i),
		.core0_data_i (core0_data_i),
		.core0_ack_o  (core0_ack_o),
		.core1_req_i  (core1_req_i),
		.core1_tag_i  (core1_tag_i),
		.core1_idx_i  (core1_idx_i),
		.core1_msg_i  (core1_msg_i),
		.core1_data_i (core1_data_i),
		.core1_ack_o  (core1_ack_o),
		.bus          (bus_req.master),
		.pend         (pend.arbiter)
	);

	rsp_queue rsp_queue_i (
		.clk         (clk),
		.rst         (rst),
		.bus         (bus_req.monitor),
		.pend        (pend.queue),
		.fill_vld_i  (fill_vld),
		.fill_ptr_i  (fill_ptr),
		.fill_data_i (fill_data),
		.rsp_vld_o   (rsp_vld_o),
		.rsp_id_o    (rsp_id_o),
		.rsp_tag_o   (rsp_tag_o),
		.rsp_idx_o   (rsp_idx_o),
		.rsp_data_o  (rsp_data_o),
		.rsp_ack_i   (rsp_ack_i)
	);

	mem_ctrl mem_ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.bus         (bus_req.slave),
		.fill_vld_o  (fill_vld),
		.fill_ptr_o  (fill_ptr),
		.fill_data_o (fill_data)
	);

endmodule

`default_nettype wire

/* verilog/mem_ctrl.sv */
`default_nettype none

module mem_ctrl (
	input  wire                 clk,
	input  wire                 rst,

	bus_req_if.slave            bus,

	output logic                fill_vld_o,
	output bus_cfg_pkg::qptr_t  fill_ptr_o,
	output bus_cfg_pkg::word_t  fill_data_o
);

	// one word per tag and index
	localparam int ADDR_W = bus_cfg_pkg::TAG_W + bus_cfg_pkg::IDX_W;
	localparam int MEM_WORDS = 2 ** ADDR_W;

	bus_cfg_pkg::word_t mem [MEM_WORDS];
	logic [ADDR_W-1:0] addr;
	logic accept;

	// fill delay line
	logic [bus_cfg_pkg::MEM_LAT-1:0] dly_vld;
	bus_cfg_pkg::qptr_t dly_ptr [bus_cfg_pkg::MEM_LAT];
	bus_cfg_pkg::word_t dly_data [bus_cfg_pkg::MEM_LAT];

	assign addr = {bus.tag, bus.idx};

	// first cycle of a new request
	assign accept = bus.req && !bus.ack;

	// --------------------
	// handshake and memory
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.ack <= 1'b0;
			dly_vld <= '0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			// ack follows req one cycle later, both edges
			bus.ack <= bus.req;
			dly_vld <= {dly_vld[bus_cfg_pkg::MEM_LAT-2:0],
				accept && bus.msg == bus_msg_pkg::GET_S};
			if (accept && bus.msg == bus_msg_pkg::PUT_M) begin
				mem[addr] <= bus.data;
			end
		end
	end

	// read data and queue slot travel together
	always_ff @(posedge clk) begin
		dly_ptr[0] <= bus.ptr;
		dly_data[0] <= mem[addr];
		for (int i = 1; i < bus_cfg_pkg::MEM_LAT; i++) begin
			dly_ptr[i] <= dly_ptr[i-1];
			dly_data[i] <= dly_data[i-1];
		end
	end

	assign fill_vld_o = dly_vld[bus_cfg_pkg::MEM_LAT-1];
	assign fill_ptr_o = dly_ptr[bus_cfg_pkg::MEM_LAT-1];
	assign fill_data_o = dly_data[bus_cfg_pkg::MEM_LAT-1];

endmodule

`default_nettype wire

/* verilog/pend_if.sv */
`default_nettype none

// pending block lookup and allocation between arbiter and queue
interface pend_if;

	// lookup address per core
	bus_cfg_pkg::tag_t tag0;
	bus_cfg_pkg::idx_t idx0;
	bus_cfg_pkg::tag_t tag1;
	bus_cfg_pkg::idx_t idx1;

	logic hit0;
	logic hit1;
	logic full;
	logic alloc;

	modport arbiter (output tag0, idx0, tag1, idx1, alloc, input hit0, hit1, full);

	modport queue (input tag0, idx0, tag1, idx1, alloc, output hit0, hit1, full);

endinterface

`default_nettype wire

/* verilog/req_arbiter.sv */
`default_nettype none

module req_arbiter (
	input  wire                       clk,
	input  wire                       rst,

	input  wire                       core0_req_i,
	input  wire bus_cfg_pkg::tag_t    core0_tag_i,
	input  wire bus_cfg_pkg::idx_t    core0_idx_i,
	input  wire bus_msg_pkg::message_t core0_msg_i,
	input  wire bus_cfg_pkg::word_t   core0_data_i,
	output logic                      core0_ack_o,

	input  wire                       core1_req_i,
	input  wire bus_cfg_pkg::tag_t    core1_tag_i,
	input  wire bus_cfg_pkg::idx_t    core1_idx_i,
	input  wire bus_msg_pkg::message_t core1_msg_i,
	input  wire bus_cfg_pkg::word_t   core1_data_i,
	output logic                      core1_ack_o,

	bus_req_if.master                 bus,
	pend_if.arbiter                   pend
);

	bus_msg_pkg::arb_state_t state_r;
	logic prio_r;
	logic elig0;
	logic elig1;
	logic gnt_vld;
	bus_cfg_pkg::core_id_t gnt_id;
	logic gnt_req;

	// both cores are looked up every cycle
	assign pend.tag0 = core0_tag_i;
	assign pend.idx0 = core0_idx_i;
	assign pend.tag1 = core1_tag_i;
	assign pend.idx1 = core1_idx_i;

	// --------------------
	// eligibility and grant
	// a pending block stalls any request, a full queue only GET_S
	assign elig0 = core0_req_i && !pend.hit0 &&
		!(core0_msg_i == bus_msg_pkg::GET_S && pend.full);
	assign elig1 = core1_req_i && !pend.hit1 &&
		!(core1_msg_i == bus_msg_pkg::GET_S && pend.full);

	assign gnt_vld = elig0 || elig1;

	always_comb begin
		if (elig0 && elig1) begin
			gnt_id = prio_r;
		end else begin
			gnt_id = elig1;
		end
	end

	// req of the core that owns the current transfer
	assign gnt_req = bus.id ? core1_req_i : core0_req_i;

	// queue entry taken in the cycle the memory ack is first seen
	assign pend.alloc = (state_r == bus_msg_pkg::ISSUE) && bus.ack &&
		(bus.msg == bus_msg_pkg::GET_S);

	// --------------------
	// transfer FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= bus_msg_pkg::IDLE;
			prio_r <= 1'b0;
			bus.req <= 1'b0;
			core0_ack_o <= 1'b0;
			core1_ack_o <= 1'b0;
		end else begin
			case (state_r)
				bus_msg_pkg::IDLE: begin
					if (gnt_vld) begin
						bus.req <= 1'b1;
						// other core goes first next time
						prio_r <= ~gnt_id;
						state_r <= bus_msg_pkg::ISSUE;
					end
				end
				bus_msg_pkg::ISSUE: begin
					if (bus.ack) begin
						bus.req <= 1'b0;
						core0_ack_o <= (bus.id == 1'b0);
						core1_ack_o <= bus.id;
						state_r <= bus_msg_pkg::CORE_ACK;
					end
				end
				bus_msg_pkg::CORE_ACK: begin
					if (!gnt_req) begin
						core0_ack_o <= 1'b0;
						core1_ack_o <= 1'b0;
						state_r <= bus_msg_pkg::DRAIN;
					end
				end
				bus_msg_pkg::DRAIN: begin
					// memory side must finish its handshake too
					if (!bus.ack) begin
						state_r <= bus_msg_pkg::IDLE;
					end
				end
				default: begin
					state_r <= bus_msg_pkg::IDLE;
				end
			endcase
		end
	end

	// request fields held for the whole internal transfer
	always_ff @(posedge clk) begin
		if (state_r == bus_msg_pkg::IDLE && gnt_vld) begin
			bus.id <= gnt_id;
			bus.tag <= gnt_id ? core1_tag_i : core0_tag_i;
			bus.idx <= gnt_id ? core1_idx_i : core0_idx_i;
			bus.msg <= gnt_id ? core1_msg_i : core0_msg_i;
			bus.data <= gnt_id ? core1_data_i : core0_data_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/rsp_queue.sv */
`default_nettype none

module rsp_queue (
	input  wire                     clk,
	input  wire                     rst,

	bus_req_if.monitor              bus,
	pend_if.queue                   pend,

	input  wire                     fill_vld_i,
	input  wire bus_cfg_pkg::qptr_t fill_ptr_i,
	input  wire bus_cfg_pkg::word_t fill_data_i,

	output logic                    rsp_vld_o,
	output bus_cfg_pkg::core_id_t   rsp_id_o,
	output bus_cfg_pkg::tag_t       rsp_tag_o,
	output bus_cfg_pkg::idx_t       rsp_idx_o,
	output bus_cfg_pkg::word_t      rsp_data_o,
	input  wire                     rsp_ack_i
);

	// entry payload
	bus_cfg_pkg::tag_t tag_q [bus_cfg_pkg::RSP_Q_NUM];
	bus_cfg_pkg::idx_t idx_q [bus_cfg_pkg::RSP_Q_NUM];
	bus_cfg_pkg::core_id_t id_q [bus_cfg_pkg::RSP_Q_NUM];
	bus_cfg_pkg::word_t data_q [bus_cfg_pkg::RSP_Q_NUM];

	// allocated, and filled by memory
	logic [bus_cfg_pkg::RSP_Q_NUM-1:0] vld_q;
	logic [bus_cfg_pkg::RSP_Q_NUM-1:0] rdy_q;

	// top bit is the wrap bit
	logic [bus_cfg_pkg::RSP_Q_PTR_W:0] head_r;
	logic [bus_cfg_pkg::RSP_Q_PTR_W:0] tail_r;
	bus_cfg_pkg::qptr_t head_idx;
	bus_cfg_pkg::qptr_t tail_idx;

	bus_msg_pkg::rsp_state_t state_r;
	logic pop;

	assign head_idx = head_r[bus_cfg_pkg::RSP_Q_PTR_W-1:0];
	assign tail_idx = tail_r[bus_cfg_pkg::RSP_Q_PTR_W-1:0];

	// same slot, different lap
	assign pend.full = (head_r[bus_cfg_pkg::RSP_Q_PTR_W] != tail_r[bus_cfg_pkg::RSP_Q_PTR_W]) &&
		(head_idx == tail_idx);

	// next GET_S lands here
	assign bus.ptr = tail_idx;

	// --------------------
	// pending block lookup
	always_comb begin
		pend.hit0 = 1'b0;
		pend.hit1 = 1'b0;
		for (int i = 0; i < bus_cfg_pkg::RSP_Q_NUM; i++) begin
			if (vld_q[i] && tag_q[i] == pend.tag0 && idx_q[i] == pend.idx0) begin
				pend.hit0 = 1'b1;
			end
			if (vld_q[i] && tag_q[i] == pend.tag1 && idx_q[i] == pend.idx1) begin
				pend.hit1 = 1'b1;
			end
		end
	end

	// --------------------
	// response delivery
	assign pop = (state_r == bus_msg_pkg::SHOW) && rsp_vld_o && rsp_ack_i;

	assign rsp_id_o = id_q[head_idx];
	assign rsp_tag_o = tag_q[head_idx];
	assign rsp_idx_o = idx_q[head_idx];
	assign rsp_data_o = data_q[head_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			vld_q <= '0;
			rdy_q <= '0;
			rsp_vld_o <= 1'b0;
			state_r <= bus_msg_pkg::SHOW;
		end else begin
			if (pend.alloc) begin
				vld_q[tail_idx] <= 1'b1;
				rdy_q[tail_idx] <= 1'b0;
				tail_r <= tail_r + 1'b1;
			end
			if (fill_vld_i) begin
				rdy_q[fill_ptr_i] <= 1'b1;
			end
			// free the head once the core has taken it
			if (pop) begin
				vld_q[head_idx] <= 1'b0;
				rdy_q[head_idx] <= 1'b0;
				head_r <= head_r + 1'b1;
			end
			case (state_r)
				bus_msg_pkg::SHOW: begin
					if (pop) begin
						rsp_vld_o <= 1'b0;
						state_r <= bus_msg_pkg::WAIT_LOW;
					end else if (!rsp_vld_o && vld_q[head_idx] && rdy_q[head_idx]) begin
						rsp_vld_o <= 1'b1;
					end
				end
				bus_msg_pkg::WAIT_LOW: begin
					// next head waits for ack to drop
					if (!rsp_ack_i) begin
						state_r <= bus_msg_pkg::SHOW;
					end
				end
				default: begin
					state_r <= bus_msg_pkg::SHOW;
				end
			endcase
		end
	end

	// payload writes
	always_ff @(posedge clk) begin
		if (pend.alloc) begin
			tag_q[tail_idx] <= bus.tag;
			idx_q[tail_idx] <= bus.idx;
			id_q[tail_idx] <= bus.id;
		end
		if (fill_vld_i) begin
			data_q[fill_ptr_i] <= fill_data_i;
		end
	end

endmodule

`default_nettype wire
